// ==== include/page_comp_cfg.svh ====
`ifndef PAGE_COMP_CFG_SVH
`define PAGE_COMP_CFG_SVH

// line and page geometry
`define PC_LINE_WIDTH 64
`define PC_PAGE_LINES 64
`define PC_CHUNK_LINES 16
`define PC_CHUNKS 4

// page buffer pointer, log2 of PC_PAGE_LINES
`define PC_PTR_WIDTH 6

// compress only when this many chunks are all zero
`define PC_MIN_ZERO_CHUNKS 3

// output FIFO entries
`define PC_OUT_DEPTH 4

`endif

// ==== design/page_comp_pkg.sv ====
`include "page_comp_cfg.svh"

package page_comp_pkg;

    // one line on the input stream or out of the page buffer
    typedef struct packed {
        logic                      err;
        logic [`PC_LINE_WIDTH-1:0] data;
    } line_beat_t;

    // bit i set when chunk i is all zero
    typedef logic [`PC_CHUNKS-1:0] chunk_map_t;

    typedef struct packed {
        logic       busy;
        logic       done;
        logic       incompressible;
        logic       bus_error;
        chunk_map_t chunk_map;
        logic [4:0] out_lines;
    } comp_status_t;

    typedef enum logic [2:0] {
        IDLE,
        CHECK,
        DECIDE,
        META,
        LOAD_PTR,
        TRANSFER,
        DONE,
        BUS_ERROR
    } comp_state_e;

    typedef enum logic [3:0] {
        REG_CTRL   = 4'h0,
        REG_STATUS = 4'h4,
        REG_RESULT = 4'h8
    } reg_addr_e;

endpackage

// ==== design/page_buffer.sv ====
`timescale 1ns/1ps
`include "page_comp_cfg.svh"

module page_buffer (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  page_comp_pkg::line_beat_t  in_beat,
    input  logic                       in_valid,
    output logic                       in_ready,
    output logic                       page_full,
    input  logic                       rd_req,
    input  logic                       ptr_load,
    input  logic [`PC_PTR_WIDTH-1:0]   ptr_value,
    input  logic                       page_release,
    output page_comp_pkg::line_beat_t  rd_beat,
    output logic                       rd_valid
);
    import page_comp_pkg::*;

    line_beat_t               mem [`PC_PAGE_LINES];
    logic [`PC_PTR_WIDTH-1:0] wr_ptr;
    logic [`PC_PTR_WIDTH-1:0] rd_ptr;
    logic                     wr_en;

    assign in_ready = !page_full;
    assign wr_en    = in_valid && in_ready;

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_beat;
        end
        if (rd_req) begin
            rd_beat <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            page_full <= 1'b0;
            rd_valid  <= 1'b0;
        end else begin
            rd_valid <= rd_req;
            if (page_release) begin
                wr_ptr    <= '0;
                rd_ptr    <= '0;
                page_full <= 1'b0;
            end else begin
                if (wr_en) begin
                    wr_ptr <= wr_ptr + 1'b1;
                    // last line of the page closes the input
                    if (wr_ptr == `PC_PTR_WIDTH'(`PC_PAGE_LINES - 1)) begin
                        page_full <= 1'b1;
                    end
                end
                // a reload wins over the auto increment
                if (ptr_load) begin
                    rd_ptr <= ptr_value;
                end else if (rd_req) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
        end
    end

    // the controller only reads a complete page
    a_rd_only_when_full: assert property (
        @(posedge clk_i) disable iff (!rst_ni) rd_req |-> page_full
    );

endmodule

// ==== design/zero_chunk_scan.sv ====
`timescale 1ns/1ps
`include "page_comp_cfg.svh"

module zero_chunk_scan (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       scan_clear,
    input  logic                       scan_en,
    input  page_comp_pkg::line_beat_t  scan_beat,
    output page_comp_pkg::chunk_map_t  chunk_map,
    output logic                       map_valid
);
    import page_comp_pkg::*;

    localparam int CW = $clog2(`PC_CHUNK_LINES);

    logic [`PC_PTR_WIDTH-1:0] line_cnt;
    logic [CW:0]              zero_cnt;
    logic                     beat_ok;
    logic                     is_zero;
    logic                     chunk_end;

    // errored beats are skipped, the controller reacts to them
    assign beat_ok   = scan_en && !scan_beat.err;
    assign is_zero   = (scan_beat.data == '0);
    assign chunk_end = (line_cnt[CW-1:0] == CW'(`PC_CHUNK_LINES - 1));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            line_cnt  <= '0;
            zero_cnt  <= '0;
            chunk_map <= '0;
            map_valid <= 1'b0;
        end else begin
            map_valid <= 1'b0;
            if (scan_clear) begin
                line_cnt  <= '0;
                zero_cnt  <= '0;
                chunk_map <= '0;
            end else if (beat_ok) begin
                line_cnt <= line_cnt + 1'b1;
                if (chunk_end) begin
                    // include the current line in the chunk verdict
                    chunk_map[line_cnt[`PC_PTR_WIDTH-1:CW]] <=
                        ((zero_cnt + (CW+1)'(is_zero)) == (CW+1)'(`PC_CHUNK_LINES));
                    zero_cnt <= '0;
                end else begin
                    zero_cnt <= zero_cnt + (CW+1)'(is_zero);
                end
                if (line_cnt == `PC_PTR_WIDTH'(`PC_PAGE_LINES - 1)) begin
                    map_valid <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== design/page_compressor.sv ====
`timescale 1ns/1ps
`include "page_comp_cfg.svh"

module page_compressor (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        start,
    input  logic                        page_full,
    input  page_comp_pkg::line_beat_t   rd_beat,
    input  logic                        rd_valid,
    input  page_comp_pkg::chunk_map_t   chunk_map,
    input  logic                        map_valid,
    input  logic                        fifo_full,
    output logic                        rd_req,
    output logic                        ptr_load,
    output logic [`PC_PTR_WIDTH-1:0]    ptr_value,
    output logic                        page_release,
    output logic                        scan_clear,
    output logic                        scan_en,
    output logic                        push,
    output logic [`PC_LINE_WIDTH-1:0]   push_data,
    output page_comp_pkg::comp_status_t status
);
    import page_comp_pkg::*;

    comp_state_e            state;
    comp_state_e            state_d;
    logic [`PC_PTR_WIDTH:0] rd_cnt;
    chunk_map_t             map_q;
    logic [4:0]             out_lines;
    logic                   done_q;
    logic                   incomp_q;
    logic                   beat_err;

    assign beat_err     = rd_valid && rd_beat.err;
    assign scan_clear   = (state == IDLE) && start;
    assign scan_en      = (state == CHECK) && rd_valid;
    assign ptr_load     = (state == LOAD_PTR) && !(&map_q);
    assign page_release = (state == DONE);

    // in TRANSFER a read only goes out when its line is sure to fit in the FIFO
    assign rd_req = ((state == CHECK) && page_full &&
                     (rd_cnt < (`PC_PTR_WIDTH+1)'(`PC_PAGE_LINES))) ||
                    ((state == TRANSFER) && !fifo_full &&
                     (rd_cnt < (`PC_PTR_WIDTH+1)'(`PC_CHUNK_LINES)));

    assign push = ((state == META) && !fifo_full) ||
                  ((state == TRANSFER) && rd_valid && !rd_beat.err);
    assign push_data = (state == META) ? `PC_LINE_WIDTH'(map_q) : rd_beat.data;

    // first chunk that is not all zero
    always_comb begin
        ptr_value = '0;
        for (int i = `PC_CHUNKS - 1; i >= 0; i--) begin
            if (!map_q[i]) begin
                ptr_value = `PC_PTR_WIDTH'(i * `PC_CHUNK_LINES);
            end
        end
    end

    always_comb begin
        state_d = state;
        case (state)
            IDLE:     if (start) state_d = CHECK;
            CHECK: begin
                if (beat_err) begin
                    state_d = BUS_ERROR;
                end else if (map_valid) begin
                    state_d = DECIDE;
                end
            end
            DECIDE: begin
                if ($countones(map_q) < `PC_MIN_ZERO_CHUNKS) begin
                    state_d = DONE;
                end else begin
                    state_d = META;
                end
            end
            META:     if (!fifo_full) state_d = LOAD_PTR;
            LOAD_PTR: state_d = (&map_q) ? DONE : TRANSFER;
            TRANSFER: begin
                if (beat_err) begin
                    state_d = BUS_ERROR;
                end else if (push && out_lines == 5'(`PC_CHUNK_LINES)) begin
                    // map line plus the whole chunk are out
                    state_d = DONE;
                end
            end
            DONE:      state_d = IDLE;
            BUS_ERROR: state_d = BUS_ERROR;
            default:   state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state     <= IDLE;
            rd_cnt    <= '0;
            map_q     <= '0;
            out_lines <= '0;
            done_q    <= 1'b0;
            incomp_q  <= 1'b0;
        end else begin
            state <= state_d;
            if (state == IDLE || state == LOAD_PTR) begin
                rd_cnt <= '0;
            end else if (rd_req) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
            if (scan_clear) begin
                map_q     <= '0;
                out_lines <= '0;
                done_q    <= 1'b0;
                incomp_q  <= 1'b0;
            end else begin
                if (state == CHECK && map_valid) map_q <= chunk_map;
                if (push) out_lines <= out_lines + 1'b1;
                if (state == DONE) done_q <= 1'b1;
                if (state == DECIDE && state_d == DONE) incomp_q <= 1'b1;
            end
        end
    end

    assign status = '{
        busy:           (state != IDLE) && (state != BUS_ERROR),
        done:           done_q,
        incompressible: incomp_q,
        bus_error:      (state == BUS_ERROR),
        chunk_map:      map_q,
        out_lines:      out_lines
    };

    a_state_known: assert property (
        @(posedge clk_i) disable iff (!rst_ni) !$isunknown(state)
    );

endmodule

// ==== design/line_fifo.sv ====
`timescale 1ns/1ps
`include "page_comp_cfg.svh"

module line_fifo (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      push,
    input  logic [`PC_LINE_WIDTH-1:0] push_data,
    output logic                      fifo_full,
    input  logic                      out_ready,
    output logic [`PC_LINE_WIDTH-1:0] out_data,
    output logic                      out_valid
);

    localparam int AW = $clog2(`PC_OUT_DEPTH);

    logic [`PC_LINE_WIDTH-1:0] mem [`PC_OUT_DEPTH];
    logic [AW-1:0]             wr_ptr;
    logic [AW-1:0]             rd_ptr;
    logic [AW:0]               count;
    logic                      pop;

    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign pop       = out_valid && out_ready;

    // one entry kept back for the read still in flight
    assign fifo_full = (count >= (AW+1)'(`PC_OUT_DEPTH - 1));

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + (AW+1)'(push) - (AW+1)'(pop);
        end
    end

    // a push lands only in a free entry or beside a pop
    a_no_overflow: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        push |-> ((count < (AW+1)'(`PC_OUT_DEPTH)) || pop)
    );

endmodule

// ==== design/apb_comp_regs.sv ====
`timescale 1ns/1ps

module apb_comp_regs (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic [3:0]                  paddr,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [31:0]                 pwdata,
    output logic [31:0]                 prdata,
    output logic                        pready,
    output logic                        pslverr,
    input  page_comp_pkg::comp_status_t status,
    output logic                        start
);
    import page_comp_pkg::*;

    logic access;
    logic addr_ok;

    // no wait states, so every access phase completes at once
    assign pready  = 1'b1;
    assign access  = psel && penable;
    assign addr_ok = (paddr == REG_CTRL) || (paddr == REG_STATUS) ||
                     (paddr == REG_RESULT);
    assign pslverr = access && !addr_ok;

    always_comb begin
        prdata = '0;
        case (paddr)
            REG_STATUS: begin
                prdata[3:0] = {status.bus_error, status.incompressible,
                               status.done, status.busy};
            end
            REG_RESULT: begin
                prdata[3:0]  = status.chunk_map;
                prdata[12:8] = status.out_lines;
            end
            default: prdata = '0;
        endcase
    end

    // start fires once per control write, ignored while a job runs
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            start <= 1'b0;
        end else begin
            start <= access && pwrite && (paddr == REG_CTRL) && pwdata[0] &&
                     !status.busy;
        end
    end

endmodule

// ==== design/page_comp_top.sv ====
`timescale 1ns/1ps
`include "page_comp_cfg.svh"

module page_comp_top (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  page_comp_pkg::line_beat_t in_beat,
    input  logic                      in_valid,
    output logic                      in_ready,
    output logic [`PC_LINE_WIDTH-1:0] out_data,
    output logic                      out_valid,
    input  logic                      out_ready,
    input  logic [3:0]                paddr,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr
);
    import page_comp_pkg::*;

    line_beat_t               rd_beat;
    chunk_map_t               chunk_map;
    comp_status_t             status;
    logic [`PC_PTR_WIDTH-1:0] ptr_value;
    logic [`PC_LINE_WIDTH-1:0] push_data;
    logic page_full, rd_req, rd_valid, ptr_load, page_release;
    logic scan_clear, scan_en, map_valid, push, fifo_full, start;

    page_buffer u_buffer (
        .clk_i, .rst_ni, .in_beat, .in_valid, .in_ready, .page_full,
        .rd_req, .ptr_load, .ptr_value, .page_release, .rd_beat, .rd_valid
    );

    zero_chunk_scan u_scan (
        .clk_i, .rst_ni, .scan_clear, .scan_en, .scan_beat(rd_beat),
        .chunk_map, .map_valid
    );

    page_compressor u_ctrl (
        .clk_i, .rst_ni, .start, .page_full, .rd_beat, .rd_valid, .chunk_map,
        .map_valid, .fifo_full, .rd_req, .ptr_load, .ptr_value, .page_release,
        .scan_clear, .scan_en, .push, .push_data, .status
    );

    line_fifo u_fifo (
        .clk_i, .rst_ni, .push, .push_data, .fifo_full, .out_ready, .out_data,
        .out_valid
    );

    apb_comp_regs u_regs (
        .clk_i, .rst_ni, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata,
        .pready, .pslverr, .status, .start
    );

endmodule

// ==== bench/tb_page_comp.sv ====
`timescale 1ns/1ps
`include "page_comp_cfg.svh"

module tb_page_comp;
    import page_comp_pkg::*;

    localparam int CLK_PERIOD      = 4;
    localparam int PAGES           = 6;
    localparam int CYCLES_PER_PAGE = 400;
    localparam int WATCHDOG_CYCLES = PAGES * CYCLES_PER_PAGE;

    logic                      clk_i = 1'b0;
    logic                      rst_ni;
    line_beat_t                in_beat;
    logic                      in_valid;
    logic                      in_ready;
    logic [`PC_LINE_WIDTH-1:0] out_data;
    logic                      out_valid;
    logic                      out_ready;
    logic [3:0]                paddr;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [31:0]               pwdata;
    logic [31:0]               prdata;
    logic                      pready;
    logic                      pslverr;

    integer                    seed = 32'he7c7;
    logic [31:0]               rnd;
    logic                      random_ready = 1'b0;
    int                        stream_errors = 0;
    int                        check_errors = 0;
    // expected output lines
    // exp_rd points at the next one due
    logic [`PC_LINE_WIDTH-1:0] exp_q[$];
    int                        exp_rd = 0;
    logic [`PC_LINE_WIDTH-1:0] page_lines [`PC_PAGE_LINES];

    page_comp_top UUT (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    always @(posedge clk_i) begin
        #1;
        if (random_ready) begin
            rnd = $random(seed);
            out_ready = rnd[0];
        end else begin
            out_ready = 1'b1;
        end
    end

    always @(posedge clk_i) begin
        if (rst_ni && out_valid && out_ready) begin
            exp_rd <= exp_rd + 1;
        end
    end

    a_no_extra_line: assert property (@(posedge clk_i) disable iff (!rst_ni)
        out_valid |-> (exp_rd < exp_q.size()))
    else begin
        stream_errors++;
        $display("[FAIL] %0t: output valid with no expected line left", $time);
    end

    a_line_value: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (out_valid && out_ready) |-> (out_data == exp_q[exp_rd]))
    else begin
        stream_errors++;
        $display("[FAIL] %0t: output line %0d is %h, expected %h", $time, exp_rd,
                 out_data, exp_q[exp_rd]);
    end

    // a stalled line must not move or vanish
    a_line_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
    else begin
        stream_errors++;
        $display("[FAIL] %0t: output line changed while stalled", $time);
    end

    task automatic apply_reset();
        rst_ni = 1'b0;
        repeat (5) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk_i);
        #1;
        penable = 1'b1;
        @(posedge clk_i);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic err);
        logic ready;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk_i);
        #1;
        penable = 1'b1;
        // access phase values are settled by the falling edge
        @(negedge clk_i);
        data  = prdata;
        err   = pslverr;
        ready = pready;
        @(posedge clk_i);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        check_value("pready", {31'b0, ready}, 32'h1);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            check_errors++;
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic poll_status(input logic [31:0] mask);
        logic [31:0] data;
        logic        err;
        apb_read(REG_STATUS, data, err);
        while ((data & mask) == '0) begin
            apb_read(REG_STATUS, data, err);
        end
    endtask

    task automatic load_page(input logic [3:0] zero_mask, input int err_line);
        line_beat_t beat;
        int         chunk;
        for (int i = 0; i < `PC_PAGE_LINES; i++) begin
            chunk = i / `PC_CHUNK_LINES;
            if (zero_mask[chunk]) begin
                page_lines[i] = '0;
            end else begin
                page_lines[i] = {$random(seed), $random(seed)};
                if (page_lines[i] == '0) begin
                    page_lines[i] = 64'h1;
                end
            end
            beat.data = page_lines[i];
            beat.err  = (i == err_line);
            in_beat   = beat;
            in_valid  = 1'b1;
            while (!in_ready) begin
                @(posedge clk_i);
                #1;
            end
            @(posedge clk_i);
            #1;
        end
        in_valid = 1'b0;
    endtask

    // map line first, then the one chunk that holds data
    task automatic queue_expected(input logic [3:0] zero_mask, output int lines);
        int first;
        first = -1;
        exp_q.push_back(`PC_LINE_WIDTH'(zero_mask));
        lines = 1;
        for (int c = `PC_CHUNKS - 1; c >= 0; c--) begin
            if (!zero_mask[c]) first = c;
        end
        if (first >= 0) begin
            for (int i = 0; i < `PC_CHUNK_LINES; i++) begin
                exp_q.push_back(page_lines[first * `PC_CHUNK_LINES + i]);
                lines++;
            end
        end
    endtask

    task automatic run_page(input logic [3:0] zero_mask);
        logic [31:0] data;
        logic        err;
        int          zeros;
        int          lines;
        zeros = 0;
        lines = 0;
        load_page(zero_mask, -1);
        for (int c = 0; c < `PC_CHUNKS; c++) begin
            if (zero_mask[c]) zeros++;
        end
        if (zeros >= `PC_MIN_ZERO_CHUNKS) begin
            queue_expected(zero_mask, lines);
        end
        apb_write(REG_CTRL, 32'h1);
        poll_status(32'h2);
        apb_read(REG_STATUS, data, err);
        check_value("STATUS", data, (zeros >= `PC_MIN_ZERO_CHUNKS) ? 32'h2 : 32'h6);
        apb_read(REG_RESULT, data, err);
        check_value("RESULT", data, {19'b0, 5'(lines), 4'b0, zero_mask});
        while (exp_rd != exp_q.size()) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    initial begin
        logic [31:0] data;
        logic        err;
        in_beat  = '0;
        in_valid = 1'b0;
        paddr    = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        pwdata   = '0;
        out_ready = 1'b1;
        apply_reset();

        apb_read(REG_STATUS, data, err);
        check_value("STATUS after reset", data, 32'h0);
        apb_read(REG_RESULT, data, err);
        check_value("RESULT after reset", data, 32'h0);
        apb_read(4'hC, data, err);
        check_value("pslverr on unmapped read", {31'b0, err}, 32'h1);

        run_page(4'b1011);
        run_page(4'b1111);
        run_page(4'b0011);

        random_ready = 1'b1;
        run_page(4'b1110);
        run_page(4'b0111);
        random_ready = 1'b0;

        // errored line in the data chunk so nothing may come out
        load_page(4'b1101, 20);
        apb_write(REG_CTRL, 32'h1);
        poll_status(32'h8);
        apb_read(REG_STATUS, data, err);
        check_value("STATUS after bus error", data, 32'h8);
        apb_write(REG_CTRL, 32'h1);
        repeat (4) @(posedge clk_i);
        #1;
        apb_read(REG_STATUS, data, err);
        check_value("STATUS after restart in error", data, 32'h8);
        apply_reset();
        apb_read(REG_STATUS, data, err);
        check_value("STATUS after second reset", data, 32'h0);

        repeat (4) @(posedge clk_i);
        $display("output errors: %0d, register errors: %0d", stream_errors, check_errors);
        if (stream_errors == 0 && check_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+include
design/page_comp_pkg.sv
design/page_buffer.sv
design/zero_chunk_scan.sv
design/page_compressor.sv
design/line_fifo.sv
design/apb_comp_regs.sv
design/page_comp_top.sv
bench/tb_page_comp.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f filelist.f --top-module tb_page_comp \
		-Mdir obj_dir -o tb_page_comp

run: compile
	-./obj_dir/tb_page_comp > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "simulation aborted"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
